/* hdl/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_BLE   = 6'h06;
    localparam opcode_t OP_BGT   = 6'h07;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_J     = 6'h02;

    // R-type function codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [3:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT,
        CLS_ADDI, CLS_SLTI, CLS_LUI,
        CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT,
        CLS_LW, CLS_SW, CLS_J,
        CLS_INVALID
    } instr_class_e;

    typedef enum logic [4:0] {
        FETCH1, FETCH2, DECODE1, DECODE2, DECODE3,
        EXE_ADD, EXE_SUB, EXE_AND, EXE_SLT, WB_RD,
        EXE_ADDI, EXE_SLTI, WB_RT, WB_LUI,
        BR_EQ, BR_NE, BR_GT, BR_LE, JUMP,
        MEM_ADDR, MEM_READ, MEM_WAIT, MDR_LOAD, WB_MEM, MEM_WRITE, WRITE_WAIT,
        TRAP_EPC, VEC_READ, VEC_WAIT, VEC_LOAD, TRAP_PC
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_CMP  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        SRCB_REG       = 2'b00,
        SRCB_FOUR      = 2'b01,
        SRCB_IMM       = 2'b10,
        SRCB_BR_OFFSET = 2'b11   // Sign extended, shifted by 2
    } alu_src_b_e;

    typedef enum logic [1:0] {
        BR_OP_EQ = 2'b00,
        BR_OP_NE = 2'b01,
        BR_OP_GT = 2'b10,
        BR_OP_LE = 2'b11
    } branch_op_e;

    typedef enum logic [2:0] {
        PCS_ALU    = 3'b000,
        PCS_ALUOUT = 3'b001,
        PCS_JUMP   = 3'b010,
        PCS_VECTOR = 3'b110
    } pc_source_e;

    typedef enum logic [2:0] {
        IORD_PC     = 3'b000,
        IORD_ALUOUT = 3'b001,
        IORD_VECTOR = 3'b010
    } iord_e;

    typedef enum logic [2:0] {
        DST_RT = 3'b000,
        DST_RD = 3'b011
    } reg_dst_e;

    typedef enum logic [3:0] {
        M2R_ALUOUT = 4'b0000,
        M2R_MDR    = 4'b0001,
        M2R_LUI    = 4'b0110,
        M2R_CMP    = 4'b1000
    } mem_to_reg_e;

endpackage

`default_nettype wire

/* hdl/instr_class_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_class_decoder
    import mips_ctrl_pkg::*;
(
    input  opcode_t      op,
    input  funct_t       funct,
    output instr_class_e instr_class
);

    always_comb begin
        instr_class = CLS_INVALID;
        case (op)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  instr_class = CLS_ADD;
                    FN_SUB:  instr_class = CLS_SUB;
                    FN_AND:  instr_class = CLS_AND;
                    FN_SLT:  instr_class = CLS_SLT;
                    default: instr_class = CLS_INVALID;  // Unknown funct traps
                endcase
            end
            OP_ADDI,
            OP_ADDIU: instr_class = CLS_ADDI;  // Same datapath, no overflow check
            OP_SLTI:  instr_class = CLS_SLTI;
            OP_LUI:   instr_class = CLS_LUI;
            OP_BEQ:   instr_class = CLS_BEQ;
            OP_BNE:   instr_class = CLS_BNE;
            OP_BLE:   instr_class = CLS_BLE;
            OP_BGT:   instr_class = CLS_BGT;
            OP_LW:    instr_class = CLS_LW;
            OP_SW:    instr_class = CLS_SW;
            OP_J:     instr_class = CLS_J;
            default:  instr_class = CLS_INVALID;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ctrl_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_sequencer
    import mips_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_e instr_class,
    output ctrl_state_e  state
);

    ctrl_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = FETCH1;
        case (state)
            // Prologue
            FETCH1:  next_state = FETCH2;
            FETCH2:  next_state = DECODE1;
            DECODE1: next_state = DECODE2;
            DECODE2: next_state = DECODE3;

            // Dispatch once the instruction register is stable
            DECODE3: begin
                case (instr_class)
                    CLS_ADD:  next_state = EXE_ADD;
                    CLS_SUB:  next_state = EXE_SUB;
                    CLS_AND:  next_state = EXE_AND;
                    CLS_SLT:  next_state = EXE_SLT;
                    CLS_ADDI: next_state = EXE_ADDI;
                    CLS_SLTI: next_state = EXE_SLTI;
                    CLS_LUI:  next_state = WB_LUI;
                    CLS_BEQ:  next_state = BR_EQ;
                    CLS_BNE:  next_state = BR_NE;
                    CLS_BLE:  next_state = BR_LE;
                    CLS_BGT:  next_state = BR_GT;
                    CLS_LW,
                    CLS_SW:   next_state = MEM_ADDR;
                    CLS_J:    next_state = JUMP;
                    default:  next_state = TRAP_EPC;
                endcase
            end

            EXE_ADD,
            EXE_SUB,
            EXE_AND,
            EXE_SLT:  next_state = WB_RD;
            EXE_ADDI,
            EXE_SLTI: next_state = WB_RT;

            MEM_ADDR: begin
                if (instr_class == CLS_LW) begin
                    next_state = MEM_READ;
                end else begin
                    next_state = MEM_WRITE;
                end
            end
            MEM_READ:  next_state = MEM_WAIT;
            MEM_WAIT:  next_state = MDR_LOAD;
            MDR_LOAD:  next_state = WB_MEM;
            MEM_WRITE: next_state = WRITE_WAIT;

            // Invalid instruction trap
            TRAP_EPC: next_state = VEC_READ;
            VEC_READ: next_state = VEC_WAIT;
            VEC_WAIT: next_state = VEC_LOAD;
            VEC_LOAD: next_state = TRAP_PC;

            // WB_*, branches, JUMP, WRITE_WAIT and TRAP_PC end the instruction
            default: next_state = FETCH1;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ctrl_output_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_output_decoder
    import mips_ctrl_pkg::*;
(
    input  ctrl_state_e state,
    output logic        ir_load,
    output logic        ab_load,
    output logic        aluout_load,
    output logic        mdr_load,
    output logic        epc_load,
    output logic        mem_write,
    output logic        reg_write,
    output logic        pc_write,
    output logic        pc_write_cond,
    output logic        alu_src_a,
    output alu_src_b_e  alu_src_b,
    output alu_op_e     alu_op,
    output branch_op_e  branch_op,
    output pc_source_e  pc_source,
    output iord_e       iord,
    output reg_dst_e    reg_dst,
    output mem_to_reg_e mem_to_reg
);

    always_comb begin
        ir_load       = 1'b0;
        ab_load       = 1'b0;
        aluout_load   = 1'b0;
        mdr_load      = 1'b0;
        epc_load      = 1'b0;
        mem_write     = 1'b0;
        reg_write     = 1'b0;
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        alu_src_a     = 1'b0;   // PC
        alu_src_b     = SRCB_REG;
        alu_op        = ALU_PASS;
        branch_op     = BR_OP_EQ;
        pc_source     = PCS_ALU;
        iord          = IORD_PC;
        reg_dst       = DST_RT;
        mem_to_reg    = M2R_ALUOUT;

        case (state)
            FETCH2: begin
                alu_src_b = SRCB_FOUR;  // PC + 4
                alu_op    = ALU_ADD;
                pc_write  = 1'b1;
            end
            DECODE1: ir_load = 1'b1;
            DECODE2: ab_load = 1'b1;
            DECODE3: begin
                // Branch target computed early
                alu_src_b   = SRCB_BR_OFFSET;
                alu_op      = ALU_ADD;
                aluout_load = 1'b1;
            end

            EXE_ADD, EXE_SUB, EXE_AND, EXE_SLT,
            EXE_ADDI, EXE_SLTI, MEM_ADDR: begin
                alu_src_a   = 1'b1;
                aluout_load = 1'b1;
                case (state)
                    EXE_SUB:  alu_op = ALU_SUB;
                    EXE_AND:  alu_op = ALU_AND;
                    EXE_SLT,
                    EXE_SLTI: alu_op = ALU_CMP;  // Set-less-than result
                    default:  alu_op = ALU_ADD;
                endcase
                if (state == EXE_ADDI || state == EXE_SLTI || state == MEM_ADDR) begin
                    alu_src_b = SRCB_IMM;
                end
            end

            WB_RD: begin
                reg_write = 1'b1;
                reg_dst   = DST_RD;
            end
            WB_RT: reg_write = 1'b1;
            WB_LUI: begin
                reg_write  = 1'b1;
                mem_to_reg = M2R_LUI;
            end

            BR_EQ, BR_NE, BR_GT, BR_LE: begin
                pc_write_cond = 1'b1;
                alu_src_a     = 1'b1;
                alu_op        = ALU_CMP;
                pc_source     = PCS_ALUOUT;
                case (state)
                    BR_NE:   branch_op = BR_OP_NE;
                    BR_GT:   branch_op = BR_OP_GT;
                    BR_LE:   branch_op = BR_OP_LE;
                    default: branch_op = BR_OP_EQ;
                endcase
            end
            JUMP: begin
                pc_write  = 1'b1;
                pc_source = PCS_JUMP;
            end

            // Address held until the data is captured
            MEM_READ, MEM_WAIT: iord = IORD_ALUOUT;
            MDR_LOAD: begin
                iord     = IORD_ALUOUT;
                mdr_load = 1'b1;
            end
            WB_MEM: begin
                reg_write  = 1'b1;
                mem_to_reg = M2R_MDR;
            end
            MEM_WRITE: begin
                iord      = IORD_ALUOUT;
                mem_write = 1'b1;
            end

            TRAP_EPC: begin
                alu_src_b = SRCB_FOUR;  // Back to the faulting instruction
                alu_op    = ALU_SUB;
                epc_load  = 1'b1;
            end
            VEC_READ, VEC_WAIT: iord = IORD_VECTOR;
            VEC_LOAD: begin
                iord     = IORD_VECTOR;
                mdr_load = 1'b1;
            end
            TRAP_PC: begin
                pc_write  = 1'b1;
                pc_source = PCS_VECTOR;
            end

            default: ;  // FETCH1 and WRITE_WAIT drive nothing
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mips_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_control_unit
    import mips_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  opcode_t     op,
    input  funct_t      funct,
    output logic        ir_load,
    output logic        ab_load,
    output logic        aluout_load,
    output logic        mdr_load,
    output logic        epc_load,
    output logic        mem_write,
    output logic        reg_write,
    output logic        pc_write,
    output logic        pc_write_cond,
    output logic        alu_src_a,
    output alu_src_b_e  alu_src_b,
    output alu_op_e     alu_op,
    output branch_op_e  branch_op,
    output pc_source_e  pc_source,
    output iord_e       iord,
    output reg_dst_e    reg_dst,
    output mem_to_reg_e mem_to_reg
);

    instr_class_e instr_class;
    ctrl_state_e  state;

    instr_class_decoder u_class (
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class)
    );

    ctrl_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .state       (state)
    );

    ctrl_output_decoder u_out (
        .state         (state),
        .ir_load       (ir_load),
        .ab_load       (ab_load),
        .aluout_load   (aluout_load),
        .mdr_load      (mdr_load),
        .epc_load      (epc_load),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .branch_op     (branch_op),
        .pc_source     (pc_source),
        .iord          (iord),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg)
    );

endmodule

`default_nettype wire

/* sim/control_unit_ref.svh */
`ifndef CONTROL_UNIT_REF_SVH
`define CONTROL_UNIT_REF_SVH

`default_nettype none

// What one instruction should do between two ir_load pulses
typedef struct packed {
    logic [3:0]  cycles;
    logic        reg_write;
    reg_dst_e    reg_dst;
    mem_to_reg_e mem_to_reg;
    logic        branch;
    branch_op_e  branch_op;
    logic        jump;
    logic        mem_write;
    logic        mdr_load;
    logic        trap;
} behavior_t;

function automatic behavior_t expected_behavior(input opcode_t op, input funct_t funct);
    behavior_t b;
    b = '0;
    case (op)
        OP_RTYPE: begin
            if (funct == FN_ADD || funct == FN_SUB || funct == FN_AND || funct == FN_SLT) begin
                b.cycles    = 4'd7;
                b.reg_write = 1'b1;
                b.reg_dst   = DST_RD;
            end else begin
                b.trap = 1'b1;
            end
        end
        OP_ADDI, OP_ADDIU, OP_SLTI: begin
            b.cycles    = 4'd7;
            b.reg_write = 1'b1;     // Into rt
        end
        OP_LUI: begin
            b.cycles     = 4'd6;
            b.reg_write  = 1'b1;
            b.mem_to_reg = M2R_LUI;
        end
        OP_BEQ, OP_BNE, OP_BLE, OP_BGT: begin
            b.cycles = 4'd6;
            b.branch = 1'b1;
            case (op)
                OP_BNE:  b.branch_op = BR_OP_NE;
                OP_BLE:  b.branch_op = BR_OP_LE;
                OP_BGT:  b.branch_op = BR_OP_GT;
                default: b.branch_op = BR_OP_EQ;
            endcase
        end
        OP_J: begin
            b.cycles = 4'd6;
            b.jump   = 1'b1;
        end
        OP_LW: begin
            b.cycles     = 4'd10;
            b.reg_write  = 1'b1;
            b.mem_to_reg = M2R_MDR;
            b.mdr_load   = 1'b1;
        end
        OP_SW: begin
            b.cycles    = 4'd8;
            b.mem_write = 1'b1;
        end
        default: b.trap = 1'b1;
    endcase
    // Trap reads the vector through the MDR
    if (b.trap) begin
        b.cycles   = 4'd10;
        b.mdr_load = 1'b1;
    end
    return b;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`default_nettype wire

`endif

/* sim/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb
    import mips_ctrl_pkg::*;
();

    localparam int NUM_INSTR   = 200;
    localparam int CYCLE_LIMIT = NUM_INSTR * 10 + 50;   // Longest instruction is 10 cycles

    `include "control_unit_ref.svh"

    logic        clk;
    logic        reset;
    opcode_t     op;
    funct_t      funct;
    logic        ir_load;
    logic        ab_load;
    logic        aluout_load;
    logic        mdr_load;
    logic        epc_load;
    logic        mem_write;
    logic        reg_write;
    logic        pc_write;
    logic        pc_write_cond;
    logic        alu_src_a;
    alu_src_b_e  alu_src_b;
    alu_op_e     alu_op;
    branch_op_e  branch_op;
    pc_source_e  pc_source;
    iord_e       iord;
    reg_dst_e    reg_dst;
    mem_to_reg_e mem_to_reg;
    logic [8:0]  strobes;
    logic [20:0] selects;

    logic [31:0] rng = 32'h9dfc;
    int          errors = 0;
    int          checks = 0;
    int          instr_count = 0;
    int          cycle_count = 0;
    int          reset_cycles = 0;
    bit          started = 1'b0;

    // Per-instruction observations
    int          window_cycles;
    int          reg_writes;
    int          cond_writes;
    int          jump_writes;
    int          vec_writes;
    int          mem_writes;
    int          mdr_loads;
    int          epc_loads;
    int          vec_reads;
    reg_dst_e    rw_dst;
    mem_to_reg_e rw_m2r;
    branch_op_e  br_op;
    pc_source_e  br_pcs;
    alu_op_e     br_alu;
    iord_e       mw_iord;

    assign strobes = {ir_load, ab_load, aluout_load, mdr_load, epc_load,
                      mem_write, reg_write, pc_write, pc_write_cond};

    // Every select, zero in FETCH1
    assign selects = {alu_src_a, alu_src_b, alu_op, branch_op,
                      pc_source, iord, reg_dst, mem_to_reg};

    mips_control_unit dut0 (
        .clk           (clk),
        .reset         (reset),
        .op            (op),
        .funct         (funct),
        .ir_load       (ir_load),
        .ab_load       (ab_load),
        .aluout_load   (aluout_load),
        .mdr_load      (mdr_load),
        .epc_load      (epc_load),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .branch_op     (branch_op),
        .pc_source     (pc_source),
        .iord          (iord),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg)
    );

    always #50 clk = ~clk;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        op    = OP_RTYPE;
        funct = FN_ADD;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    function automatic logic [11:0] valid_instr(input logic [31:0] r);
        logic [5:0] fill;
        fill = r[21:16];    // funct field is ignored outside R-type
        case (r[15:8] % 15)
            0:       return {OP_RTYPE, FN_ADD};
            1:       return {OP_RTYPE, FN_SUB};
            2:       return {OP_RTYPE, FN_AND};
            3:       return {OP_RTYPE, FN_SLT};
            4:       return {OP_ADDI, fill};
            5:       return {OP_ADDIU, fill};
            6:       return {OP_SLTI, fill};
            7:       return {OP_LUI, fill};
            8:       return {OP_BEQ, fill};
            9:       return {OP_BNE, fill};
            10:      return {OP_BLE, fill};
            11:      return {OP_BGT, fill};
            12:      return {OP_LW, fill};
            13:      return {OP_SW, fill};
            default: return {OP_J, fill};
        endcase
    endfunction

    // Dropped opcodes and dropped R-type functions
    function automatic logic [11:0] invalid_instr(input logic [31:0] r);
        logic [5:0] fill;
        fill = r[21:16];
        case (r[10:8])
            3'd0:    return {6'h01, fill};
            3'd1:    return {6'h03, fill};      // JAL
            3'd2:    return {6'h0c, fill};
            3'd3:    return {6'h20, fill};      // LB
            3'd4:    return {OP_RTYPE, 6'h00};  // SLL
            3'd5:    return {OP_RTYPE, 6'h08};  // JR
            3'd6:    return {OP_RTYPE, 6'h18};  // MULT
            default: return {OP_RTYPE, 6'h0d};  // BREAK
        endcase
    endfunction

    task automatic check_value(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("ERROR: %s = 0x%0h, expected 0x%0h (op 0x%02h funct 0x%02h) at %0t",
                     name, got, want, op, funct, $time);
        end
    endtask

    task automatic clear_window();
        window_cycles = 0;
        reg_writes    = 0;
        cond_writes   = 0;
        jump_writes   = 0;
        vec_writes    = 0;
        mem_writes    = 0;
        mdr_loads     = 0;
        epc_loads     = 0;
        vec_reads     = 0;
    endtask

    task automatic compare_window();
        behavior_t want;
        want = expected_behavior(op, funct);
        check_value("cycles between ir_load", window_cycles, want.cycles);
        check_value("reg_write count", reg_writes, want.reg_write);
        if (want.reg_write) begin
            check_value("reg_dst", rw_dst, want.reg_dst);
            check_value("mem_to_reg", rw_m2r, want.mem_to_reg);
        end
        check_value("pc_write_cond count", cond_writes, want.branch);
        if (want.branch) begin
            check_value("branch_op", br_op, want.branch_op);
            check_value("pc_source", br_pcs, PCS_ALUOUT);
            check_value("alu_op", br_alu, ALU_CMP);
        end
        check_value("pc_write jump count", jump_writes, want.jump);
        check_value("mem_write count", mem_writes, want.mem_write);
        if (want.mem_write) begin
            check_value("iord", mw_iord, IORD_ALUOUT);
        end
        check_value("mdr_load count", mdr_loads, want.mdr_load);
        check_value("epc_load count", epc_loads, want.trap);
        check_value("iord vector read", vec_reads != 0, want.trap);
        check_value("pc_write vector count", vec_writes, want.trap);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checks: %0d  errors: %0d  instructions: %0d", checks, errors, instr_count);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Next instruction goes out as the instruction register loads
    always @(posedge clk) begin
        if (!reset && ir_load) begin
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0) begin
                {op, funct} <= invalid_instr(rng);
            end else begin
                {op, funct} <= valid_instr(rng);
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            if (reset_cycles > 0) begin
                check_value("strobes in reset", strobes, 0);
                check_value("selects in reset", selects, 0);
            end
            reset_cycles++;
            clear_window();
        end else begin
            window_cycles++;
            if (reg_write) begin
                reg_writes++;
                rw_dst = reg_dst;
                rw_m2r = mem_to_reg;
            end
            if (pc_write_cond) begin
                cond_writes++;
                br_op  = branch_op;
                br_pcs = pc_source;
                br_alu = alu_op;
            end
            if (pc_write && pc_source == PCS_JUMP) jump_writes++;
            if (pc_write && pc_source == PCS_VECTOR) vec_writes++;
            if (mem_write) begin
                mem_writes++;
                mw_iord = iord;
            end
            if (mdr_load) mdr_loads++;
            if (epc_load) epc_loads++;
            if (iord == IORD_VECTOR) vec_reads++;
            if (ir_load) begin
                if (started) begin
                    compare_window();
                    instr_count++;
                end else begin
                    check_value("cycles to first ir_load", window_cycles, 3);
                    started = 1'b1;
                end
                clear_window();
                if (instr_count == NUM_INSTR) finish_run(1'b0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles with %0d of %0d instructions checked",
                     cycle_count, instr_count, NUM_INSTR);
            finish_run(1'b1);
        end
    end

endmodule

`default_nettype wire

/* mips_control_unit.f */
+incdir+sim
hdl/mips_ctrl_pkg.sv
hdl/instr_class_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_output_decoder.sv
hdl/mips_control_unit.sv
sim/control_unit_tb.sv

/* Bender.yml */
package:
  name: mips_control_unit

sources:
  - files:
      - hdl/mips_ctrl_pkg.sv
      - hdl/instr_class_decoder.sv
      - hdl/ctrl_sequencer.sv
      - hdl/ctrl_output_decoder.sv
      - hdl/mips_control_unit.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/control_unit_tb.sv
